// File: verilog/icache_pkg.sv
package icache_pkg;

    // Line geometry
    localparam int BEATS    = 4;
    localparam int OFFSET_W = 4;

    // Virtual or physical byte address
    typedef logic [31:0] addr_t;

    // One bus beat
    typedef logic [31:0] word_t;

    // Full cache line with beat 0 in the low word
    typedef logic [127:0] line_t;

    // Controller sequencing
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        BUS_WAIT,
        FILL,
        WRITE,
        RESPOND
    } ctrl_state_t;

endpackage

// File: verilog/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int INDEX_W = 5
) (
    input  logic              clk,
    input  logic              arst_n,

    input  logic              req_valid,
    output logic              req_ready,
    input  icache_pkg::addr_t req_address,
    output logic              dp_valid,
    input  logic              dp_ready,

    output icache_pkg::addr_t virt_addr,
    input  logic              tlb_hit,
    input  logic              tlb_pcd,

    input  logic              hit,
    output logic              store_write,
    output logic              fetch_start,
    output logic              fill_clear,
    input  logic              line_done,
    output logic              resp_from_fill
);

    localparam int TAG_W = 32 - icache_pkg::OFFSET_W - INDEX_W;

    icache_pkg::ctrl_state_t state;
    icache_pkg::ctrl_state_t state_nxt;

    // Fetches are always line aligned so only tag and index are kept
    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_index;

    logic pcd_q;
    logic req_accept;
    logic lookup_hit;

    assign req_accept = req_valid && req_ready;

    // Cache-disabled pages never count as hits
    assign lookup_hit = hit && !tlb_pcd;

    always_ff @(posedge clk) begin
        if (req_accept) begin
            req_tag   <= req_address[31 -: TAG_W];
            req_index <= req_address[icache_pkg::OFFSET_W +: INDEX_W];
        end
    end

    assign virt_addr = {req_tag, req_index, {icache_pkg::OFFSET_W{1'b0}}};

    always_comb begin
        state_nxt   = state;
        fetch_start = 1'b0;
        fill_clear  = 1'b0;
        store_write = 1'b0;
        case (state)
            icache_pkg::IDLE: begin
                if (req_valid) begin
                    state_nxt = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::LOOKUP: begin
                // Wait here until translation is available
                if (tlb_hit) begin
                    if (lookup_hit) begin
                        state_nxt = icache_pkg::RESPOND;
                    end else begin
                        fetch_start = 1'b1;
                        state_nxt   = icache_pkg::BUS_WAIT;
                    end
                end
            end
            icache_pkg::BUS_WAIT: begin
                // Drop the previous line before new beats show up
                fill_clear = 1'b1;
                state_nxt  = icache_pkg::FILL;
            end
            icache_pkg::FILL: begin
                if (line_done) begin
                    state_nxt = pcd_q ? icache_pkg::RESPOND : icache_pkg::WRITE;
                end
            end
            icache_pkg::WRITE: begin
                store_write = 1'b1;
                state_nxt   = icache_pkg::RESPOND;
            end
            icache_pkg::RESPOND: begin
                if (dp_ready) begin
                    state_nxt = icache_pkg::IDLE;
                end
            end
            default: begin
                state_nxt = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state          <= icache_pkg::IDLE;
            pcd_q          <= 1'b0;
            resp_from_fill <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == icache_pkg::LOOKUP && tlb_hit) begin
                pcd_q          <= tlb_pcd;
                resp_from_fill <= !lookup_hit;
            end
        end
    end

    assign req_ready = (state == icache_pkg::IDLE);
    assign dp_valid  = (state == icache_pkg::RESPOND);

    // Response, its source and its index held until the fetch stage takes it
    a_dp_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        dp_valid && !dp_ready |=> dp_valid && $stable(resp_from_fill) && $stable(virt_addr)
    ) else $error("response changed without dp_ready");

    // Only a cacheable miss may be written into the store
    a_write_cacheable: assert property (
        @(posedge clk) disable iff (!arst_n)
        store_write |-> !pcd_q && resp_from_fill
    ) else $error("store written for a hit or an uncached fetch");

    // A freshly written line should hit on the same translation
    a_write_then_hit: assert property (
        @(posedge clk) disable iff (!arst_n)
        store_write |=> (hit || !tlb_hit)
    ) else $error("line written to store does not hit");

endmodule

// File: verilog/icache_store.sv
`timescale 1ns/1ps

module icache_store #(
    parameter int INDEX_W = 5
) (
    input  logic              clk,
    input  logic              arst_n,

    input  icache_pkg::addr_t virt_addr,
    input  icache_pkg::addr_t phys_addr,

    input  logic              store_write,
    input  icache_pkg::line_t fill_line,

    output logic              hit,
    output icache_pkg::line_t read_line
);

    localparam int LINES = 2 ** INDEX_W;
    localparam int TAG_W = 32 - icache_pkg::OFFSET_W - INDEX_W;

    logic [LINES-1:0]  valid_q;
    logic [TAG_W-1:0]  tag_q [LINES];
    icache_pkg::line_t data_q [LINES];

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   phys_tag;
    logic               tag_match;

    // Index bits sit inside the page offset so the virtual index is safe
    assign index    = virt_addr[icache_pkg::OFFSET_W +: INDEX_W];
    assign phys_tag = phys_addr[31 -: TAG_W];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (store_write) begin
            valid_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (store_write) begin
            tag_q[index]  <= phys_tag;
            data_q[index] <= fill_line;
        end
    end

    // Tag compare against the translated address
    assign tag_match = (tag_q[index] == phys_tag);
    assign hit       = valid_q[index] && tag_match;

    assign read_line = data_q[index];

endmodule

// File: verilog/fill_buffer.sv
`timescale 1ns/1ps

module fill_buffer (
    input  logic              clk,
    input  logic              arst_n,

    input  logic              fill_clear,
    input  logic              beat_valid,
    input  icache_pkg::word_t beat_data,

    output logic              line_done,
    output icache_pkg::line_t fill_line
);

    localparam int CNT_W = $clog2(icache_pkg::BEATS);

    logic [CNT_W-1:0]  beat_cnt;
    icache_pkg::word_t words [icache_pkg::BEATS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat_cnt  <= '0;
            line_done <= 1'b0;
        end else if (fill_clear) begin
            beat_cnt  <= '0;
            line_done <= 1'b0;
        end else if (beat_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == CNT_W'(icache_pkg::BEATS - 1)) begin
                line_done <= 1'b1;
            end
        end
    end

    // Beats land in arrival order
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            words[beat_cnt] <= beat_data;
        end
    end

    always_comb begin
        for (int i = 0; i < icache_pkg::BEATS; i++) begin
            fill_line[i*32 +: 32] = words[i];
        end
    end

    // Fetcher must stop after the last beat of the line
    a_no_extra_beat: assert property (
        @(posedge clk) disable iff (!arst_n)
        beat_valid |-> !line_done
    ) else $error("beat arrived after line was complete");

endmodule

// File: verilog/bus_fetch.sv
`timescale 1ns/1ps

module bus_fetch (
    input  logic              clk,
    input  logic              arst_n,

    input  logic              fetch_start,
    input  icache_pkg::addr_t phys_addr,

    output logic              mem_req,
    input  logic              grant_in,
    output logic              grant_out,
    input  logic              bus_busy_in,
    output logic              bus_busy_out,
    output logic              mem_en,
    output icache_pkg::addr_t mem_addr,
    input  logic              mem_data_valid,
    input  icache_pkg::word_t mem_data,

    output logic              beat_valid,
    output icache_pkg::word_t beat_data
);

    localparam int CNT_W = $clog2(icache_pkg::BEATS);

    logic             req_pend;
    logic             own;
    logic [CNT_W-1:0] beat_cnt;
    logic             take_bus;
    logic             last_beat;

    // Grant reaches us only while the bus is idle
    assign take_bus  = req_pend && grant_in && !bus_busy_in;
    assign beat_valid = own && mem_data_valid;
    assign last_beat = beat_valid && (beat_cnt == CNT_W'(icache_pkg::BEATS - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_pend <= 1'b0;
            own      <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (fetch_start) begin
                req_pend <= 1'b1;
                beat_cnt <= '0;
            end else if (take_bus) begin
                req_pend <= 1'b0;
                own      <= 1'b1;
            end else if (beat_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    own <= 1'b0;
                end
            end
        end
    end

    // Word address walks up the line one beat at a time
    always_ff @(posedge clk) begin
        if (fetch_start) begin
            mem_addr <= {phys_addr[31:icache_pkg::OFFSET_W], {icache_pkg::OFFSET_W{1'b0}}};
        end else if (beat_valid) begin
            mem_addr <= mem_addr + 32'd4;
        end
    end

    assign mem_req      = req_pend || own;
    assign grant_out    = grant_in && !mem_req;
    assign bus_busy_out = own;
    assign mem_en       = own;
    assign beat_data    = mem_data;

    // Ownership starts only on a granted and free bus
    a_take_free_bus: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(mem_en) |-> $past(grant_in && !bus_busy_in)
    ) else $error("bus taken while not granted or busy");

    a_hold_to_last_beat: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_en && !last_beat |=> mem_en
    ) else $error("bus released before the fourth beat");

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter int INDEX_W = 5
) (
    input  logic              clk,
    input  logic              arst_n,

    // Fetch stage
    input  logic              req_valid,
    output logic              req_ready,
    input  icache_pkg::addr_t req_address,
    output logic              dp_valid,
    input  logic              dp_ready,
    output icache_pkg::line_t dp_read_data,

    // TLB
    output icache_pkg::addr_t virt_addr,
    input  icache_pkg::addr_t phys_addr,
    input  logic              tlb_hit,
    input  logic              tlb_pcd,

    // Shared read bus
    output icache_pkg::addr_t mem_addr,
    output logic              mem_req,
    input  logic              mem_data_valid,
    input  icache_pkg::word_t mem_data,
    output logic              mem_en,

    // Daisy-chain arbitration
    input  logic              grant_in,
    output logic              grant_out,
    output logic              bus_busy_out,
    input  logic              bus_busy_in
);

    logic              hit;
    logic              store_write;
    logic              fetch_start;
    logic              fill_clear;
    logic              line_done;
    logic              resp_from_fill;
    logic              beat_valid;
    icache_pkg::word_t beat_data;
    icache_pkg::line_t fill_line;
    icache_pkg::line_t read_line;

    icache_ctrl #(
        .INDEX_W (INDEX_W)
    ) i_icache_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_address    (req_address),
        .dp_valid       (dp_valid),
        .dp_ready       (dp_ready),
        .virt_addr      (virt_addr),
        .tlb_hit        (tlb_hit),
        .tlb_pcd        (tlb_pcd),
        .hit            (hit),
        .store_write    (store_write),
        .fetch_start    (fetch_start),
        .fill_clear     (fill_clear),
        .line_done      (line_done),
        .resp_from_fill (resp_from_fill)
    );

    icache_store #(
        .INDEX_W (INDEX_W)
    ) i_icache_store (
        .clk         (clk),
        .arst_n      (arst_n),
        .virt_addr   (virt_addr),
        .phys_addr   (phys_addr),
        .store_write (store_write),
        .fill_line   (fill_line),
        .hit         (hit),
        .read_line   (read_line)
    );

    fill_buffer i_fill_buffer (
        .clk        (clk),
        .arst_n     (arst_n),
        .fill_clear (fill_clear),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .line_done  (line_done),
        .fill_line  (fill_line)
    );

    bus_fetch i_bus_fetch (
        .clk            (clk),
        .arst_n         (arst_n),
        .fetch_start    (fetch_start),
        .phys_addr      (phys_addr),
        .mem_req        (mem_req),
        .grant_in       (grant_in),
        .grant_out      (grant_out),
        .bus_busy_in    (bus_busy_in),
        .bus_busy_out   (bus_busy_out),
        .mem_en         (mem_en),
        .mem_addr       (mem_addr),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data),
        .beat_valid     (beat_valid),
        .beat_data      (beat_data)
    );

    // Misses and uncached fetches answer from the fill buffer
    assign dp_read_data = resp_from_fill ? fill_line : read_line;

endmodule

// File: bench/mem_bus_model.sv
`timescale 1ns/1ps

module mem_bus_model #(
    parameter logic [31:0] SEED = 32'h7f3a_6d68
) (
    input  logic              clk,
    input  logic              arst_n,

    input  logic              mem_en,
    input  icache_pkg::addr_t mem_addr,
    output logic              mem_data_valid,
    output icache_pkg::word_t mem_data,

    // Second master and upstream arbiter
    input  logic              other_own,
    input  logic              grant_block,
    output logic              grant_in,
    output logic              bus_busy_in
);

    localparam logic [31:0] DATA_KEY = 32'hC0DE_0000;

    logic [31:0] rng;
    int          wait_cnt;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Latency of 1 to 4 cycles per beat
    function automatic int pick_latency(input logic [31:0] s);
        return int'(s[17:16]) + 1;
    endfunction

    initial begin
        rng            = SEED;
        wait_cnt       = 1;
        mem_data_valid = 1'b0;
        mem_data       = '0;
    end

    always @(negedge clk) begin
        if (!arst_n || !mem_en) begin
            mem_data_valid <= 1'b0;
        end else if (mem_data_valid) begin
            // One beat per strobe, address steps at the next edge
            mem_data_valid <= 1'b0;
        end else if (wait_cnt <= 1) begin
            mem_data_valid <= 1'b1;
            mem_data       <= mem_addr ^ DATA_KEY;
            rng             = lcg_step(rng);
            wait_cnt        = pick_latency(rng);
        end else begin
            wait_cnt = wait_cnt - 1;
        end
    end

    // The other master keeps the bus busy while it owns it
    assign bus_busy_in = other_own;
    assign grant_in    = !grant_block;

endmodule

// File: bench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam time CLK_PERIOD = 40ns;
    localparam int  N_TESTS    = 6;

    logic              clk;
    logic              arst_n;
    logic              req_valid;
    logic              req_ready;
    icache_pkg::addr_t req_address;
    logic              dp_valid;
    logic              dp_ready;
    icache_pkg::line_t dp_read_data;
    icache_pkg::addr_t virt_addr;
    icache_pkg::addr_t phys_addr;
    logic              tlb_hit;
    logic              tlb_pcd;
    icache_pkg::addr_t mem_addr;
    logic              mem_req;
    logic              mem_data_valid;
    icache_pkg::word_t mem_data;
    logic              mem_en;
    logic              grant_in;
    logic              grant_out;
    logic              bus_busy_out;
    logic              bus_busy_in;
    logic              other_own;
    logic              grant_block;

    int                errors;
    int                checks;
    logic              mem_req_seen;
    icache_pkg::addr_t addr_log[$];
    logic [31:0]       rng;

    icache_top #(
        .INDEX_W (5)
    ) i_icache_top (
        .clk            (clk),
        .arst_n         (arst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_address    (req_address),
        .dp_valid       (dp_valid),
        .dp_ready       (dp_ready),
        .dp_read_data   (dp_read_data),
        .virt_addr      (virt_addr),
        .phys_addr      (phys_addr),
        .tlb_hit        (tlb_hit),
        .tlb_pcd        (tlb_pcd),
        .mem_addr       (mem_addr),
        .mem_req        (mem_req),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data),
        .mem_en         (mem_en),
        .grant_in       (grant_in),
        .grant_out      (grant_out),
        .bus_busy_out   (bus_busy_out),
        .bus_busy_in    (bus_busy_in)
    );

    mem_bus_model #(
        .SEED (32'h7f3a_6d68)
    ) i_mem_bus_model (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_en         (mem_en),
        .mem_addr       (mem_addr),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data),
        .other_own      (other_own),
        .grant_block    (grant_block),
        .grant_in       (grant_in),
        .bus_busy_in    (bus_busy_in)
    );

    // TLB model, fixed offset translation
    assign phys_addr = virt_addr ^ 32'h0010_0000;
    assign tlb_pcd   = (virt_addr >= 32'h8000_0000);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * 200 * N_TESTS);
        $display("Watchdog expired, the DUT stopped responding");
        $display("=== FAIL ===");
        $finish;
    end

    // Bus monitors, sampled where DUT outputs are stable
    always @(negedge clk) begin
        if (mem_req) begin
            mem_req_seen = 1'b1;
        end
        if (mem_en && (addr_log.size() == 0 || addr_log[$] != mem_addr)) begin
            addr_log.push_back(mem_addr);
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic icache_pkg::addr_t line_phys(input icache_pkg::addr_t va);
        icache_pkg::addr_t pa;
        pa = va ^ 32'h0010_0000;
        return {pa[31:4], 4'h0};
    endfunction

    // Line from the memory rule at the translated address
    function automatic icache_pkg::line_t expected_line(input icache_pkg::addr_t va);
        icache_pkg::line_t l;
        icache_pkg::addr_t pa;
        pa = line_phys(va);
        for (int i = 0; i < 4; i++) begin
            l[i*32 +: 32] = (pa + 32'(i * 4)) ^ 32'hC0DE_0000;
        end
        return l;
    endfunction

    task automatic check_line(input icache_pkg::line_t act, input icache_pkg::line_t exp,
                              input string msg);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH @%0t: %s exp %h got %h", $time, msg, exp, act);
        end
    endtask

    task automatic check_addr(input icache_pkg::addr_t act, input icache_pkg::addr_t exp,
                              input string msg);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH @%0t: %s exp %h got %h", $time, msg, exp, act);
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string msg);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH @%0t: %s exp %b got %b", $time, msg, exp, act);
        end
    endtask

    task automatic issue_request(input icache_pkg::addr_t a);
        @(negedge clk);
        mem_req_seen = 1'b0;
        addr_log.delete();
        req_valid   = 1'b1;
        req_address = a;
        while (!req_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // Cycles are counted from acceptance until dp_valid
    task automatic wait_response(input int hold, output icache_pkg::line_t data,
                                 output int cycles);
        icache_pkg::line_t first;
        cycles = 0;
        while (!dp_valid) begin
            @(negedge clk);
            cycles++;
        end
        first = dp_read_data;
        repeat (hold) begin
            @(negedge clk);
            check_flag(dp_valid, 1'b1, "dp_valid held under back-pressure");
            check_flag(req_ready, 1'b0, "req_ready while response pending");
            check_line(dp_read_data, first, "dp_read_data stable under back-pressure");
        end
        data     = dp_read_data;
        dp_ready = 1'b1;
        @(negedge clk);
        dp_ready = 1'b0;
    endtask

    task automatic fetch_line(input icache_pkg::addr_t a, input int hold,
                              output icache_pkg::line_t data, output int cycles);
        issue_request(a);
        wait_response(hold, data, cycles);
    endtask

    task automatic test_cold_miss();
        icache_pkg::line_t d;
        int                c;
        fetch_line(32'h0000_1230, 0, d, c);
        check_line(d, expected_line(32'h0000_1230), "cold miss line");
        check_addr(virt_addr, 32'h0000_1230, "virt_addr holds the request");
        check_flag(addr_log.size() == 4, 1'b1, "four word addresses on the bus");
        for (int i = 0; i < 4 && i < addr_log.size(); i++) begin
            check_addr(addr_log[i], line_phys(32'h0000_1230) + 32'(i * 4), "mem_addr beat");
        end
    endtask

    task automatic test_repeat_hit();
        icache_pkg::line_t d;
        int                c;
        fetch_line(32'h0000_1230, 0, d, c);
        check_line(d, expected_line(32'h0000_1230), "hit line");
        check_flag(c == 1, 1'b1, "hit answers one cycle after acceptance");
        check_flag(mem_req_seen, 1'b0, "mem_req on a hit");
    endtask

    task automatic test_uncached();
        icache_pkg::line_t d;
        int                c;
        for (int i = 0; i < 2; i++) begin
            fetch_line(32'h8000_2040, 0, d, c);
            check_line(d, expected_line(32'h8000_2040), "uncached line");
            check_flag(mem_req_seen, 1'b1, "uncached fetch goes to the bus");
        end
    endtask

    task automatic test_alias();
        icache_pkg::addr_t a;
        icache_pkg::line_t d;
        int                c;
        for (int i = 0; i < 4; i++) begin
            a = (i % 2 == 0) ? 32'h0000_3050 : 32'h0004_3050;
            fetch_line(a, 0, d, c);
            check_line(d, expected_line(a), "aliased line");
            check_flag(mem_req_seen, 1'b1, "aliased fetch misses");
        end
    endtask

    task automatic test_stall();
        icache_pkg::line_t d;
        int                c;
        rng = lcg_step(rng);
        fetch_line(32'h0000_4060, 1 + int'(rng[19:16]), d, c);
        check_line(d, expected_line(32'h0000_4060), "line after back-pressure");
        @(negedge clk);
        tlb_hit = 1'b0;
        issue_request(32'h0000_1230);
        repeat (5) begin
            @(negedge clk);
            check_flag(dp_valid, 1'b0, "response during TLB miss");
        end
        tlb_hit = 1'b1;
        wait_response(0, d, c);
        check_line(d, expected_line(32'h0000_1230), "line after TLB wait");
    endtask

    task automatic test_arbitration();
        icache_pkg::line_t d;
        int                c;
        @(negedge clk);
        grant_block = 1'b1;
        @(negedge clk);
        check_flag(grant_out, 1'b0, "grant_out follows low grant_in when idle");
        grant_block = 1'b0;
        other_own   = 1'b1;
        @(negedge clk);
        check_flag(grant_out, 1'b1, "grant_out follows high grant_in when idle");
        issue_request(32'h0000_5070);
        @(negedge clk);
        repeat (6) begin
            @(negedge clk);
            check_flag(mem_en, 1'b0, "mem_en while bus busy");
            check_flag(bus_busy_out, 1'b0, "bus_busy_out before ownership");
            check_flag(mem_req, 1'b1, "mem_req while waiting");
            check_flag(grant_out, 1'b0, "grant_out while requesting");
        end
        other_own   = 1'b0;
        grant_block = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_flag(mem_en, 1'b0, "mem_en without grant");
            check_flag(grant_out, 1'b0, "grant_out while requesting");
        end
        grant_block = 1'b0;
        @(negedge clk);
        check_flag(grant_out, 1'b0, "grant_out while owning");
        check_flag(mem_en, 1'b1, "mem_en once granted on a free bus");
        check_flag(bus_busy_out, 1'b1, "bus_busy_out while owning");
        wait_response(0, d, c);
        check_line(d, expected_line(32'h0000_5070), "line after arbitration");
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        rng         = 32'h7f3a_6d68;
        arst_n      = 1'b0;
        req_valid   = 1'b0;
        req_address = '0;
        dp_ready    = 1'b0;
        tlb_hit     = 1'b1;
        other_own   = 1'b0;
        grant_block = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_flag(req_ready, 1'b1, "req_ready after reset");
        check_flag(dp_valid, 1'b0, "dp_valid after reset");
        check_flag(mem_req, 1'b0, "mem_req after reset");
        check_flag(mem_en, 1'b0, "mem_en after reset");
        check_flag(bus_busy_out, 1'b0, "bus_busy_out after reset");

        test_cold_miss();
        test_repeat_hit();
        test_uncached();
        test_alias();
        test_stall();
        test_arbitration();

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: project.f
verilog/icache_pkg.sv
verilog/icache_ctrl.sv
verilog/icache_store.sv
verilog/fill_buffer.sv
verilog/bus_fetch.sv
verilog/icache_top.sv
bench/mem_bus_model.sv
bench/icache_tb.sv

// File: Makefile
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

PASS_TEXT := === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
